// ==== rtl/grayPkg.sv ====
`default_nettype none

package grayPkg;

	localparam int posWidth = 8;  // Bits per channel position
	localparam int laneCount = 4; // Encoder channels in one sample word

	// One strobe carries every channel, field i goes to lane i
	typedef struct packed {
		logic [laneCount-1:0][posWidth-1:0] gray; // Raw Gray codes
	} sampleWordT;

	// Per-channel result, step is two's complement modulo 2**posWidth
	typedef struct packed {
		logic [posWidth-1:0] position; // Binary position
		logic [posWidth-1:0] step;     // Position minus previous position
		logic                skip;     // Step outside -1..+1
	} laneResultT;

	// Record handed to the consumer
	typedef struct packed {
		laneResultT [laneCount-1:0] lanes;
		logic       [laneCount-1:0] faultMask; // Sticky skips, cleared by software
	} decodedT;

endpackage

`default_nettype wire

// ==== rtl/PrefixXor.sv ====
`timescale 1ns/1ns
`default_nettype none

// Running XOR over a word, PO[i] = PI[0] ^ ... ^ PI[i]
// Depth and area traded through speed
module PrefixXor #(
	parameter int width = 8, // Word size
	parameter int speed = 2  // 2 Sklansky, 1 Brent-Kung, else serial
) (
	input  logic [width-1:0] PI, // Bits to accumulate
	output logic [width-1:0] PO  // Prefix XOR, bit 0 upward
);

	localparam int depth = $clog2(width); // Levels of a full binary tree

	if (speed == 2) begin : sklansky
		// Minimum depth, high fanout on block tops
		logic [depth:0][width-1:0] pt;

		assign pt[0] = PI;

		for (genvar l = 1; l <= depth; l++) begin : level
			for (genvar i = 0; i < width; i++) begin : node
				localparam int half = 2 ** (l - 1);          // Span of a finished block
				localparam int src = (i / (2 * half)) * 2 * half + half - 1; // Its top bit
				if (((i / half) % 2) == 1) begin : merge
					assign pt[l][i] = pt[l-1][i] ^ pt[l-1][src]; // Upper half joins lower block
				end else begin : pass
					assign pt[l][i] = pt[l-1][i];
				end
			end
		end

		assign PO = pt[depth];

	end else if (speed == 1) begin : brentKung
		// Up-sweep then down-sweep, fanout of two at most
		logic [2*depth-1:0][width-1:0] pt;

		assign pt[0] = PI;

		// Combine pairs at the top of ever larger blocks
		for (genvar l = 1; l <= depth; l++) begin : up
			for (genvar i = 0; i < width; i++) begin : node
				localparam int span = 2 ** l;
				if (((i + 1) % span) == 0) begin : merge
					assign pt[l][i] = pt[l-1][i] ^ pt[l-1][i-span/2];
				end else begin : pass
					assign pt[l][i] = pt[l-1][i];
				end
			end
		end

		// Midpoints pick up the finished prefix just below them
		for (genvar l = depth + 1; l < 2 * depth; l++) begin : down
			for (genvar i = 0; i < width; i++) begin : node
				localparam int span = 2 ** (2 * depth - l); // Halves each level
				if ((((i + 1) % span) == span / 2) && ((i + 1) > span)) begin : merge
					assign pt[l][i] = pt[l-1][i] ^ pt[l-1][i-span/2];
				end else begin : pass
					assign pt[l][i] = pt[l-1][i];
				end
			end
		end

		assign PO = pt[2*depth-1];

	end else begin : serial
		// Ripple chain, width-1 gates deep
		logic [width-1:0] pt;

		assign pt[0] = PI[0];
		for (genvar i = 1; i < width; i++) begin : node
			assign pt[i] = pt[i-1] ^ PI[i];
		end

		assign PO = pt;
	end

endmodule

`default_nettype wire

// ==== rtl/graySampler.sv ====
`timescale 1ns/1ns
`default_nettype none

// Input register for the whole sample word
// Word is only loaded on the strobe, so lanes see a held value in between
module graySampler (
	input  logic                clk,
	input  logic                reset,
	input  logic                sampleValid,   // One-cycle capture strobe
	input  grayPkg::sampleWordT sample,        // All channels, Gray coded
	output logic                capturedValid, // Strobe delayed by one cycle
	output grayPkg::sampleWordT captured       // Held sample word
);

	// Strobe pipeline
	always_ff @(posedge clk) begin
		if (reset) begin
			capturedValid <= 1'b0;
		end else begin
			capturedValid <= sampleValid;
		end
	end

	// Sample payload, kept until the next strobe
	always_ff @(posedge clk) begin
		if (sampleValid) begin
			captured <= sample; // Every channel at once
		end
	end

	// Lanes and collector key everything off this strobe
	capturedValidKnown: assert property (
		@(posedge clk) disable iff (reset)
		!$isunknown(capturedValid)
	) else $error("graySampler: capturedValid unknown");

endmodule

`default_nettype wire

// ==== rtl/grayLane.sv ====
`timescale 1ns/1ns
`default_nettype none

// One channel: Gray to binary, step from previous sample, skip flag
module grayLane #(
	parameter int speed = 2 // Prefix network structure
) (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          capturedValid, // Fresh sample word
	input  logic [grayPkg::posWidth-1:0]  gray,          // This channel's field
	output logic                          laneValid,
	output grayPkg::laneResultT           laneResult
);

	import grayPkg::*;

	logic [posWidth-1:0] grayRev;   // MSB placed at bit 0
	logic [posWidth-1:0] binRev;    // Prefix result, still reversed
	logic [posWidth-1:0] binary;    // Binary position, normal order
	logic [posWidth-1:0] delta;     // Modular step, zero until primed
	logic                jump;      // Step not in -1, 0, +1
	logic                primed;    // Previous position is valid
	logic [posWidth-1:0] positionQ; // Also the previous position
	logic [posWidth-1:0] stepQ;
	logic                skipQ;

	// Binary bit i is XOR of Gray bits i and up, so run the prefix from the MSB
	always_comb begin
		for (int i = 0; i < posWidth; i++) begin
			grayRev[i] = gray[posWidth-1-i];
		end
	end

	PrefixXor #(
		.width(posWidth),
		.speed(speed)
	) i_prefixXor (
		.PI(grayRev),
		.PO(binRev)
	);

	always_comb begin
		for (int i = 0; i < posWidth; i++) begin
			binary[i] = binRev[posWidth-1-i]; // Back to normal order
		end
	end

	assign delta = primed ? binary - positionQ : '0; // Wraps modulo 2**posWidth
	assign jump = !((delta == '0) || (delta == posWidth'(1)) || (delta == '1));

	always_ff @(posedge clk) begin
		if (reset) begin
			laneValid <= 1'b0;
			skipQ <= 1'b0;
			primed <= 1'b0;
		end else begin
			laneValid <= capturedValid;
			skipQ <= capturedValid & jump; // Only alongside a new result
			if (capturedValid) begin
				primed <= 1'b1; // First sample only primes
			end
		end
	end

	always_ff @(posedge clk) begin
		if (capturedValid) begin
			positionQ <= binary;
			stepQ <= delta;
		end
	end

	assign laneResult = '{position: positionQ, step: stepQ, skip: skipQ};

	// Collector ORs skip into the sticky mask
	skipOnlyWhenValid: assert property (
		@(posedge clk) disable iff (reset)
		laneResult.skip |-> laneValid
	) else $error("grayLane: skip without laneValid");

endmodule

`default_nettype wire

// ==== rtl/positionCollector.sv ====
`timescale 1ns/1ns
`default_nettype none

// Builds the output record and keeps the sticky fault mask
module positionCollector (
	input  logic                                        clk,
	input  logic                                        reset,
	input  logic [grayPkg::laneCount-1:0]               laneValid,
	input  grayPkg::laneResultT [grayPkg::laneCount-1:0] laneResult,
	input  logic                                        clearFault, // Software clear
	output logic                                        outValid,
	output grayPkg::decodedT                            decoded
);

	import grayPkg::*;

	laneResultT [laneCount-1:0] lanesQ;    // Registered lane results
	logic       [laneCount-1:0] faultMask; // Sticky per-channel skips
	logic       [laneCount-1:0] newSkips;

	always_comb begin
		for (int i = 0; i < laneCount; i++) begin
			newSkips[i] = laneValid[i] & laneResult[i].skip;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			outValid <= 1'b0;
			faultMask <= '0;
		end else begin
			outValid <= laneValid[0]; // All lanes share one strobe
			// Clear first, then a skip in the same cycle sets its bit again
			faultMask <= (clearFault ? {laneCount{1'b0}} : faultMask) | newSkips;
		end
	end

	always_ff @(posedge clk) begin
		if (laneValid[0]) begin
			lanesQ <= laneResult;
		end
	end

	assign decoded = '{lanes: lanesQ, faultMask: faultMask};

	// Lanes run in lockstep from the sampler strobe
	lanesInLockstep: assert property (
		@(posedge clk) disable iff (reset)
		(&laneValid) || !(|laneValid)
	) else $error("positionCollector: lane valids differ");

endmodule

`default_nettype wire

// ==== rtl/grayDecoderTop.sv ====
`timescale 1ns/1ns
`default_nettype none

// Sampler -> lanes -> collector, 3 cycles from sampleValid to outValid
module grayDecoderTop #(
	parameter int speed = 2 // Prefix structure for every lane
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                sampleValid,
	input  grayPkg::sampleWordT sample,
	input  logic                clearFault,
	output logic                outValid,
	output grayPkg::decodedT    decoded
);

	import grayPkg::*;

	logic                       capturedValid;
	sampleWordT                 captured;
	logic       [laneCount-1:0] laneValid;
	laneResultT [laneCount-1:0] laneResult;

	graySampler i_sampler (
		.clk          (clk),
		.reset        (reset),
		.sampleValid  (sampleValid),
		.sample       (sample),
		.capturedValid(capturedValid),
		.captured     (captured)
	);

	// One lane per channel field
	for (genvar i = 0; i < laneCount; i++) begin : lane
		grayLane #(
			.speed(speed)
		) i_lane (
			.clk          (clk),
			.reset        (reset),
			.capturedValid(capturedValid),
			.gray         (captured.gray[i]),
			.laneValid    (laneValid[i]),
			.laneResult   (laneResult[i])
		);
	end

	positionCollector i_collector (
		.clk       (clk),
		.reset     (reset),
		.laneValid (laneValid),
		.laneResult(laneResult),
		.clearFault(clearFault),
		.outValid  (outValid),
		.decoded   (decoded)
	);

endmodule

`default_nettype wire

// ==== tb/grayChecker.sv ====
`timescale 1ns/1ns
`default_nettype none

// Scoreboard, rebuilds every output record from the DUT inputs alone
module grayChecker (
	input  logic                clk,
	input  logic                reset,
	input  logic                sampleValid,
	input  grayPkg::sampleWordT sample,
	input  logic                clearFault,
	input  logic [2:0]          testId,     // Test that issued the strobe
	input  logic                outValid,
	input  grayPkg::decodedT    decoded,
	input  logic                drainCheck, // Stimulus done, nothing may be left
	output int                  errorCount
);

	import grayPkg::*;

	typedef struct packed {
		logic        valid;
		sampleWordT  word;
		logic [2:0]  testId;
		logic [31:0] cycle; // Edge that took the strobe
	} stageT;

	typedef struct packed {
		decodedT     record;
		logic [31:0] strobeCycle;
		logic [2:0]  testId;
	} expectT;

	expectT                             expQ[$]; // Records still owed by the DUT
	stageT                              stage1;  // Sample one edge past the strobe
	stageT                              stage2;  // At the collector edge
	logic [laneCount-1:0][posWidth-1:0] prevPos; // Last binary position per channel
	logic                               primed;
	logic [laneCount-1:0]               mask;    // Sticky skips as the DUT should hold them
	logic [31:0]                        cycle = '0;
	int                                 errors = 0;

	assign errorCount = errors;

	function automatic string testName(input logic [2:0] id);
		case (id)
			3'd1: return "conversion";
			3'd2: return "walk";
			3'd3: return "skip";
			3'd4: return "clear";
			3'd5: return "throughput";
			default: return "unknown";
		endcase
	endfunction

	// Expected record for one Gray word, from the previous positions and mask
	function automatic decodedT expectRecord(
		input logic [laneCount-1:0][posWidth-1:0] prev,
		input logic                               primedIn,
		input logic [laneCount-1:0]               maskIn,
		input sampleWordT                         word,
		input logic                               clear
	);
		decodedT             rec;
		logic [posWidth-1:0] g;
		logic [posWidth-1:0] b;
		logic [posWidth-1:0] d;
		int                  fwd; // Forward distance from prev, wraps at 2**posWidth
		rec.faultMask = clear ? '0 : maskIn; // A fresh skip still lands after a clear
		for (int i = 0; i < laneCount; i++) begin
			g = word.gray[i];
			for (int k = 0; k < posWidth; k++) begin
				b[k] = ^(g >> k); // Gray bits k and above
			end
			fwd = (int'(b) - int'(prev[i]) + (1 << posWidth)) % (1 << posWidth);
			d = primedIn ? posWidth'(fwd) : '0; // First sample only primes
			rec.lanes[i].position = b;
			rec.lanes[i].step = d;
			// Forward 1 is +1, top value is -1
			rec.lanes[i].skip = primedIn && (fwd > 1) && (fwd < (1 << posWidth) - 1);
			rec.faultMask[i] = rec.faultMask[i] | rec.lanes[i].skip;
		end
		return rec;
	endfunction

	always @(posedge clk) begin : scoreboard
		decodedT exp;
		expectT  entry;
		cycle = cycle + 1;
		if (reset) begin
			stage1 = '0;
			stage2 = '0;
			primed = 1'b0;
			mask = '0;
			prevPos = '0;
			expQ.delete();
		end else begin
			if (outValid) begin
				if (expQ.size() == 0) begin
					$display("ERROR: output record at cycle %0d without a pending sample", cycle);
					errors++;
				end else begin
					entry = expQ.pop_front();
					if (decoded !== entry.record) begin
						$display("CHECK FAILED %s: expected %h actual %h",
							testName(entry.testId), entry.record, decoded);
						errors++;
					end
					if (cycle != entry.strobeCycle + 3) begin // Fixed 3-cycle latency
						$display("CHECK FAILED %s latency: expected 3 actual %0d",
							testName(entry.testId), cycle - entry.strobeCycle);
						errors++;
					end
				end
			end
			if (stage2.valid) begin
				exp = expectRecord(prevPos, primed, mask, stage2.word, clearFault);
				for (int i = 0; i < laneCount; i++) begin
					prevPos[i] = exp.lanes[i].position;
				end
				mask = exp.faultMask;
				primed = 1'b1;
				entry.record = exp;
				entry.strobeCycle = stage2.cycle;
				entry.testId = stage2.testId;
				expQ.push_back(entry);
			end else if (clearFault) begin
				mask = '0; // Clear with no record in flight
			end
			stage2 = stage1;
			stage1.valid = sampleValid;
			stage1.word = sample;
			stage1.testId = testId;
			stage1.cycle = cycle;
			if (drainCheck && (expQ.size() != 0 || stage1.valid || stage2.valid)) begin
				$display("ERROR: %0d sample records never came out", expQ.size());
				errors++;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb/tbGrayDecoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module tbGrayDecoder;

	import grayPkg::*;

	localparam int cycleLimit = 2000; // About 500 cycles of stimulus plus margin

	logic                               clk;
	logic                               reset;
	logic                               sampleValid;
	sampleWordT                         sample;
	logic                               clearFault;
	logic                               outValid;
	decodedT                            decoded;
	logic [2:0]                         testId;
	logic                               drainCheck;
	int                                 errorCount;
	int                                 cycles = 0;
	logic [laneCount-1:0][posWidth-1:0] pos; // Binary positions behind the stimulus
	int                                 lane;

	grayDecoderTop #(
		.speed(2)
	) i_dut (
		.clk        (clk),
		.reset      (reset),
		.sampleValid(sampleValid),
		.sample     (sample),
		.clearFault (clearFault),
		.outValid   (outValid),
		.decoded    (decoded)
	);

	grayChecker i_checker (
		.clk        (clk),
		.reset      (reset),
		.sampleValid(sampleValid),
		.sample     (sample),
		.clearFault (clearFault),
		.testId     (testId),
		.outValid   (outValid),
		.decoded    (decoded),
		.drainCheck (drainCheck),
		.errorCount (errorCount)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("ERROR: run still going after %0d cycles, %0d errors", cycleLimit, errorCount);
			$display("Simulation failed");
			$finish;
		end
	end

	// Encoders report b ^ (b >> 1)
	function automatic sampleWordT grayWord(input logic [laneCount-1:0][posWidth-1:0] bin);
		sampleWordT w;
		for (int i = 0; i < laneCount; i++) begin
			w.gray[i] = bin[i] ^ (bin[i] >> 1);
		end
		return w;
	endfunction

	task automatic strobe(input logic [2:0] id, input logic clear);
		@(posedge clk);
		sampleValid <= 1'b1;
		sample <= grayWord(pos);
		testId <= id;
		clearFault <= clear;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			sampleValid <= 1'b0;
			clearFault <= 1'b0;
		end
	endtask

	task automatic pulseClear();
		@(posedge clk);
		sampleValid <= 1'b0;
		clearFault <= 1'b1;
		@(posedge clk);
		clearFault <= 1'b0;
	endtask

	task automatic walkAll();
		for (int i = 0; i < laneCount; i++) begin
			pos[i] = pos[i] + posWidth'($urandom_range(2, 0)) - posWidth'(1); // -1, 0 or +1
		end
	endtask

	initial begin
		void'($urandom(32'h8f77_da4e));
		reset = 1'b1;
		sampleValid = 1'b0;
		sample = '0;
		clearFault = 1'b0;
		testId = 3'd0;
		drainCheck = 1'b0;
		pos = '0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		repeat (40) begin // Random words, first one primes
			for (int i = 0; i < laneCount; i++) begin
				pos[i] = posWidth'($urandom);
			end
			strobe(3'd1, 1'b0);
			idle($urandom_range(2, 0));
		end
		pulseClear();
		repeat (60) begin
			walkAll();
			strobe(3'd2, 1'b0);
			idle($urandom_range(1, 0));
		end
		repeat (30) begin // Jump one lane by 2 or more
			walkAll();
			lane = $urandom_range(laneCount - 1, 0);
			pos[lane] = pos[lane] + posWidth'($urandom_range(253, 3)); // Walk plus jump still 2 away
			strobe(3'd3, 1'b0);
			walkAll();
			strobe(3'd3, 1'b0); // Clean sample, mask stays
			idle($urandom_range(2, 0));
		end
		repeat (6) begin
			pulseClear();
			idle(3);
			strobe(3'd4, 1'b0);
			lane = $urandom_range(laneCount - 1, 0);
			pos[lane] = pos[lane] + posWidth'($urandom_range(254, 2));
			strobe(3'd4, 1'b0);
			idle(1);
			pulseClear(); // Meets that skip at the collector
			idle(3);
			strobe(3'd4, 1'b0);
			idle(2);
		end
		repeat (20) begin // Bursts with gaps
			repeat ($urandom_range(6, 1)) begin
				walkAll();
				strobe(3'd5, 1'b0);
			end
			idle($urandom_range(3, 0));
		end
		idle(8);
		@(posedge clk);
		drainCheck <= 1'b1;
		@(posedge clk);
		drainCheck <= 1'b0;
		@(posedge clk);
		$display("Closing report: %0d errors", errorCount);
		if (errorCount == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/grayPkg.sv
rtl/PrefixXor.sv
rtl/graySampler.sv
rtl/grayLane.sv
rtl/positionCollector.sv
rtl/grayDecoderTop.sv
tb/grayChecker.sv
tb/tbGrayDecoder.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the Gray decoder testbench

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f verilog.f --top-module tbGrayDecoder -o simGray
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simGray > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# The log decides pass or fail
if grep -q "^Simulation completed successfully$" sim.log; then
	exit 0
fi
exit 1
